// File: include/ps2_consts.svh
`ifndef PS2_CONSTS_SVH
`define PS2_CONSTS_SVH

// Flip-flops in each input synchronizer chain
`define PS2_SYNC_STAGES 2

// System clocks a synchronized line must hold still before the filtered level follows
`define PS2_DEBOUNCE_CYCLES 4

// System clocks without a falling edge before a partial frame is thrown away
`define PS2_IDLE_CYCLES 400

// Scan code buffer entries, also the credits the receiver owns after reset
`define SCAN_FIFO_DEPTH 8

// Set-2 prefix bytes
`define PS2_PREFIX_EXT 8'hE0   // Extended key follows
`define PS2_PREFIX_BREAK 8'hF0 // Key released, the code follows

`endif

// File: source/ps2_line_pkg.sv
package ps2_line_pkg;

	// One byte as it comes off the wire, data bits only
	typedef logic [7:0] scan_code_t;

	// Phases of the frame receiver
	// IDLE waits for the first falling edge of a frame
	// SHIFT collects the remaining ten bits
	// DONE holds the full word for one cycle while it is checked
	typedef enum logic [1:0] {
		IDLE,
		SHIFT,
		DONE
	} rx_state_t;

endpackage

// File: source/key_event_pkg.sv
package key_event_pkg;

	// A decoded key transition
	// Field order puts the flags above the code so a flat dump reads naturally
	typedef struct packed {
		logic                     extended; // Code was preceded by E0
		logic                     released; // Code was preceded by F0, key went up
		ps2_line_pkg::scan_code_t code;     // Final non-prefix byte
	} key_event_t;

endpackage

// File: source/ps2_line_filter.sv
`include "ps2_consts.svh"

module ps2_line_filter (
	input  logic clk,
	input  logic rst,
	input  logic ps2_clk,   // Keyboard clock as seen on the pin
	input  logic ps2_data,  // Keyboard data as seen on the pin
	output logic line_data, // Debounced data level
	output logic fall,      // Single-cycle pulse on each falling edge of the debounced clock
	output logic line_idle  // High while the debounced clock rests high
);

	localparam int SYNC_N = `PS2_SYNC_STAGES;
	localparam int DEB_N  = `PS2_DEBOUNCE_CYCLES;
	localparam int CNT_W  = $clog2(DEB_N + 1);

	// Both lines are handled by the same logic, index 0 is clock and index 1 is data
	logic [1:0]             raw;
	logic [1:0][SYNC_N-1:0] sync_q;     // Synchronizer chains, MSB is the settled end
	logic [1:0][CNT_W-1:0]  stable_cnt; // Cycles the synchronized level has differed
	logic [1:0]             filt_q;     // Filtered levels
	logic                   clk_prev_q; // Filtered clock one cycle back

	assign raw = {ps2_data, ps2_clk};

	always_ff @(posedge clk) begin
		if (rst) begin
			sync_q     <= '1; // Open-collector lines float high when nobody drives them
			stable_cnt <= '0;
			filt_q     <= '1;
			clk_prev_q <= 1'b1;
		end else begin
			for (int i = 0; i < 2; i++) begin
				sync_q[i] <= {sync_q[i][SYNC_N-2:0], raw[i]};

				// The filtered level moves only after DEB_N cycles of disagreement in a row
				if (sync_q[i][SYNC_N-1] == filt_q[i]) begin
					stable_cnt[i] <= '0; // Glitch ended or nothing changed
				end else if (stable_cnt[i] == CNT_W'(DEB_N - 1)) begin
					filt_q[i]     <= sync_q[i][SYNC_N-1];
					stable_cnt[i] <= '0;
				end else begin
					stable_cnt[i] <= stable_cnt[i] + 1'b1;
				end
			end
			clk_prev_q <= filt_q[0];
		end
	end

	// High in the first cycle the filtered clock reads low
	assign fall      = clk_prev_q & ~filt_q[0];
	assign line_data = filt_q[1];
	assign line_idle = filt_q[0];

endmodule

// File: source/ps2_frame_receiver.sv
`include "ps2_consts.svh"

module ps2_frame_receiver (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     line_data,     // Debounced data, valid while fall is high
	input  logic                     fall,          // Sample strobe from the line filter
	input  logic                     credit_return, // One credit back per buffer entry removed
	output logic                     push,          // Good frame with credit available
	output ps2_line_pkg::scan_code_t push_code,
	output logic                     frame_error,   // Start, parity or stop was wrong
	output logic                     overrun        // Good frame but the buffer had no room
);
	import ps2_line_pkg::*;

	localparam int IDLE_W   = $clog2(`PS2_IDLE_CYCLES);
	localparam int CREDIT_W = $clog2(`SCAN_FIFO_DEPTH + 1);

	rx_state_t           state_q;
	logic [10:0]         word_q;   // Bit 0 ends up holding start, bit 10 holds stop
	logic [3:0]          bit_cnt;  // Bits taken in so far
	logic [IDLE_W-1:0]   idle_cnt; // Cycles since the last fall while in SHIFT
	logic [CREDIT_W-1:0] credit_q; // Free entries in the buffer as the receiver sees them
	logic                frame_ok;
	logic                has_credit;

	// Bits arrive LSB first so each new bit enters at the top and moves down
	always_ff @(posedge clk) begin
		if (fall && state_q != DONE) begin
			word_q <= {line_data, word_q[10:1]};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q  <= IDLE;
			bit_cnt  <= '0;
			idle_cnt <= '0;
		end else begin
			case (state_q)
				IDLE: begin
					idle_cnt <= '0;
					if (fall) begin // First edge of a frame carries the start bit
						bit_cnt <= 4'd1;
						state_q <= SHIFT;
					end
				end
				SHIFT: begin
					if (fall) begin
						idle_cnt <= '0;
						bit_cnt  <= bit_cnt + 1'b1;
						if (bit_cnt == 4'd10) state_q <= DONE; // This edge sampled the stop bit
					end else if (idle_cnt == IDLE_W'(`PS2_IDLE_CYCLES - 1)) begin
						// Keyboard went quiet mid-frame, drop what we have without a report
						bit_cnt  <= '0;
						idle_cnt <= '0;
						state_q  <= IDLE;
					end else begin
						idle_cnt <= idle_cnt + 1'b1;
					end
				end
				DONE: begin
					bit_cnt <= '0; // Word was judged this cycle
					state_q <= IDLE;
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// Start low, stop high, and an odd number of ones over data plus parity
	assign frame_ok   = ~word_q[0] & word_q[10] & (^word_q[9:1]);
	assign has_credit = credit_q != '0;

	assign push        = (state_q == DONE) && frame_ok && has_credit;
	assign overrun     = (state_q == DONE) && frame_ok && !has_credit;
	assign frame_error = (state_q == DONE) && !frame_ok;
	assign push_code   = word_q[8:1];

	// A push spends a credit, a return gives one back, both together cancel
	always_ff @(posedge clk) begin
		if (rst) begin
			credit_q <= CREDIT_W'(`SCAN_FIFO_DEPTH);
		end else begin
			case ({push, credit_return})
				2'b10:   credit_q <= credit_q - 1'b1;
				2'b01:   credit_q <= credit_q + 1'b1;
				default: credit_q <= credit_q;
			endcase
		end
	end

endmodule

// File: source/scan_code_fifo.sv
`include "ps2_consts.svh"

module scan_code_fifo (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     push,          // Never raised while full, credits see to that
	input  ps2_line_pkg::scan_code_t push_code,
	input  logic                     pop,
	output logic                     head_valid,
	output ps2_line_pkg::scan_code_t head_code,
	output logic                     credit_return  // One pulse per entry taken out
);
	import ps2_line_pkg::*;

	localparam int DEPTH = `SCAN_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	scan_code_t       mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count; // Entries currently held
	logic             do_pop;

	// Wraps explicitly so a depth that is not a power of two still works
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign do_pop = pop & head_valid; // A pop on an empty buffer is ignored

	always_ff @(posedge clk) begin
		if (push) mem[wr_ptr] <= push_code;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop) rd_ptr <= ptr_inc(rd_ptr);
			case ({push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head is read straight out of the array, so a push shows up one cycle later
	assign head_valid    = count != '0;
	assign head_code     = mem[rd_ptr];
	assign credit_return = do_pop;

endmodule

// File: source/scan_code_decoder.sv
`include "ps2_consts.svh"

module scan_code_decoder (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      head_valid,
	input  ps2_line_pkg::scan_code_t  head_code,
	input  logic                      event_ready,
	output logic                      pop,
	output logic                      event_valid,
	output key_event_pkg::key_event_t key_event
);

	logic ext_q;     // E0 seen since the last event
	logic brk_q;     // F0 seen since the last event
	logic is_ext;
	logic is_brk;
	logic slot_free; // Event register can take a new value at the next edge
	logic load;      // Final byte of a sequence is being popped

	assign is_ext    = head_code == `PS2_PREFIX_EXT;
	assign is_brk    = head_code == `PS2_PREFIX_BREAK;
	assign slot_free = !event_valid || event_ready;

	// Prefixes wait too, that keeps the byte order simple
	assign pop  = head_valid && slot_free;
	assign load = pop && !is_ext && !is_brk;

	always_ff @(posedge clk) begin
		if (rst) begin
			event_valid <= 1'b0;
			ext_q       <= 1'b0;
			brk_q       <= 1'b0;
		end else begin
			if (event_valid && event_ready) event_valid <= 1'b0; // Transfer happened
			if (pop) begin
				if (is_ext) begin
					ext_q <= 1'b1;
				end else if (is_brk) begin
					brk_q <= 1'b1;
				end else begin
					event_valid <= 1'b1; // Overrides the clear above on back-to-back events
					ext_q       <= 1'b0;
					brk_q       <= 1'b0;
				end
			end
		end
	end

	// Event payload holds still until the consumer takes it
	always_ff @(posedge clk) begin
		if (load) begin
			key_event <= '{extended: ext_q, released: brk_q, code: head_code};
		end
	end

endmodule

// File: source/ps2_keyboard_rx.sv
module ps2_keyboard_rx (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     ps2_clk,
	input  logic                     ps2_data,
	input  logic                     event_ready,
	output logic                     event_valid,
	output ps2_line_pkg::scan_code_t event_code,
	output logic                     event_release,
	output logic                     event_extended,
	output logic                     frame_error,
	output logic                     overrun
);
	import ps2_line_pkg::*;
	import key_event_pkg::*;

	logic       line_data;
	logic       fall;
	logic       push;
	scan_code_t push_code;
	logic       credit_return;
	logic       head_valid;
	scan_code_t head_code;
	logic       pop;
	key_event_t key_event;

	// Bus idle level has no user on this receive-only path
	ps2_line_filter u_filter (
		.clk       (clk),
		.rst       (rst),
		.ps2_clk   (ps2_clk),
		.ps2_data  (ps2_data),
		.line_data (line_data),
		.fall      (fall),
		.line_idle ()
	);

	ps2_frame_receiver u_receiver (
		.clk           (clk),
		.rst           (rst),
		.line_data     (line_data),
		.fall          (fall),
		.credit_return (credit_return),
		.push          (push),
		.push_code     (push_code),
		.frame_error   (frame_error),
		.overrun       (overrun)
	);

	scan_code_fifo u_fifo (
		.clk           (clk),
		.rst           (rst),
		.push          (push),
		.push_code     (push_code),
		.pop           (pop),
		.head_valid    (head_valid),
		.head_code     (head_code),
		.credit_return (credit_return)
	);

	scan_code_decoder u_decoder (
		.clk         (clk),
		.rst         (rst),
		.head_valid  (head_valid),
		.head_code   (head_code),
		.event_ready (event_ready),
		.pop         (pop),
		.event_valid (event_valid),
		.key_event   (key_event)
	);

	// Flat ports for the outside world
	assign event_code     = key_event.code;
	assign event_release  = key_event.released;
	assign event_extended = key_event.extended;

endmodule

// File: verif/ps2_keyboard_model.sv
`include "ps2_consts.svh"

module ps2_keyboard_model #(
	parameter int HALF_CLKS  = 24, // System clocks per half period of the keyboard clock
	parameter int GAP_HALVES = 2   // Idle half periods the keyboard leaves after each frame
) (
	input  logic clk,
	output logic ps2_clk,
	output logic ps2_data
);
	timeunit 1ns;
	timeprecision 100ps;

	// Open-collector lines rest high while the keyboard is silent
	initial begin
		ps2_clk  = 1'b1;
		ps2_data = 1'b1;
	end

	// Start bit, data LSB first, parity, stop bit, bit 0 goes out first
	function automatic logic [10:0] build_frame(input logic [7:0] code, input logic bad_parity);
		logic parity;
		parity = (~^code) ^ bad_parity; // Odd parity unless asked to corrupt it
		return {1'b1, parity, code, 1'b0};
	endfunction

	// Line changes land a little after a system clock edge
	task automatic wait_half();
		repeat (HALF_CLKS) @(posedge clk);
		#2;
	endtask

	// Data is set while the clock is high, the host samples it on the falling edge
	task automatic shift_out(input logic [10:0] word, input int nbits);
		for (int i = 0; i < nbits; i++) begin
			ps2_data = word[i];
			wait_half();
			ps2_clk = 1'b0;
			wait_half();
			ps2_clk = 1'b1;
		end
		ps2_data = 1'b1; // Release data after the last bit
		repeat (GAP_HALVES) wait_half();
	endtask

	// Whole good frame
	task automatic send_byte(input logic [7:0] code);
		shift_out(build_frame(code, 1'b0), 11);
	endtask

	// Whole frame whose parity bit is inverted
	task automatic send_bad_parity(input logic [7:0] code);
		shift_out(build_frame(code, 1'b1), 11);
	endtask

	// Only the first nbits go out, then the keyboard stays quiet past the idle limit
	task automatic send_partial(input logic [7:0] code, input int nbits);
		shift_out(build_frame(code, 1'b0), nbits);
		repeat (2 * `PS2_IDLE_CYCLES) @(posedge clk);
		#2;
	endtask

endmodule

// File: verif/tb_ps2_keyboard_rx.sv
`include "ps2_consts.svh"

module tb_ps2_keyboard_rx;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int     HALF_CLKS    = 24;
	localparam int     CLK_NS       = 40;
	localparam int     SEED         = 12638;
	localparam int     TOTAL_FRAMES = 42; // 20 + 7 + 2 + 2 + 11 frames over all tests
	localparam longint WATCHDOG_NS  = 2 * TOTAL_FRAMES * 22 * HALF_CLKS * CLK_NS;
	localparam int     DRAIN_CLKS   = 4 * (`SCAN_FIFO_DEPTH + 1); // Buffer plus event register

	logic       clk;
	logic       rst;
	logic       ps2_clk;
	logic       ps2_data;
	logic       event_ready;
	logic       event_valid;
	logic [7:0] event_code;
	logic       event_release;
	logic       event_extended;
	logic       frame_error;
	logic       overrun;

	logic [9:0] exp_mem [64]; // Expected events as {extended, release, code}
	int         exp_wr = 0;
	int         exp_rd = 0;
	logic       pend_ext = 1'b0; // Prefix flags of the sequence being typed
	logic       pend_rel = 1'b0;
	logic       err_allowed;
	logic       ovr_allowed;
	int         err_count = 0;
	int         ovr_count = 0;

	ps2_keyboard_rx dut (
		.clk            (clk),
		.rst            (rst),
		.ps2_clk        (ps2_clk),
		.ps2_data       (ps2_data),
		.event_ready    (event_ready),
		.event_valid    (event_valid),
		.event_code     (event_code),
		.event_release  (event_release),
		.event_extended (event_extended),
		.frame_error    (frame_error),
		.overrun        (overrun)
	);

	ps2_keyboard_model #(.HALF_CLKS(HALF_CLKS)) kbd (
		.clk      (clk),
		.ps2_clk  (ps2_clk),
		.ps2_data (ps2_data)
	);

	always #(CLK_NS / 2) clk = ~clk;

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	// Scoreboard head moves on once this edge's checks have seen it
	always @(posedge clk) begin
		if (!rst && event_valid && event_ready) begin
			#5;
			exp_rd = exp_rd + 1;
		end
	end

	always @(posedge clk) begin
		if (!rst && frame_error) err_count <= err_count + 1;
		if (!rst && overrun) ovr_count <= ovr_count + 1;
	end

	a_event_expected: assert property (@(posedge clk) disable iff (rst)
		(event_valid && event_ready) |-> (exp_rd < exp_wr))
		else stop_with_failure("A key event was delivered when none was expected");
	a_event_code: assert property (@(posedge clk) disable iff (rst)
		(event_valid && event_ready && exp_rd < exp_wr) |->
		(event_code == exp_mem[exp_rd][7:0]))
		else stop_with_failure($sformatf("[ERROR] event_code is %h, expected %h",
			$sampled(event_code), exp_mem[exp_rd][7:0]));
	a_event_release: assert property (@(posedge clk) disable iff (rst)
		(event_valid && event_ready && exp_rd < exp_wr) |->
		(event_release == exp_mem[exp_rd][8]))
		else stop_with_failure($sformatf("[ERROR] event_release is %h, expected %h",
			$sampled(event_release), exp_mem[exp_rd][8]));
	a_event_extended: assert property (@(posedge clk) disable iff (rst)
		(event_valid && event_ready && exp_rd < exp_wr) |->
		(event_extended == exp_mem[exp_rd][9]))
		else stop_with_failure($sformatf("[ERROR] event_extended is %h, expected %h",
			$sampled(event_extended), exp_mem[exp_rd][9]));
	a_no_frame_error: assert property (@(posedge clk) disable iff (rst) frame_error |-> err_allowed)
		else stop_with_failure($sformatf("[ERROR] frame_error is %h, expected %h", 1'b1, 1'b0));
	a_no_overrun: assert property (@(posedge clk) disable iff (rst) overrun |-> ovr_allowed)
		else stop_with_failure($sformatf("[ERROR] overrun is %h, expected %h", 1'b1, 1'b0));
	a_valid_held: assert property (@(posedge clk) disable iff (rst)
		$past(event_valid && !event_ready) |-> event_valid)
		else stop_with_failure("event_valid dropped before the event was taken");
	a_event_stable: assert property (@(posedge clk) disable iff (rst)
		$past(event_valid && !event_ready) |->
		({event_extended, event_release, event_code} ==
			$past({event_extended, event_release, event_code})))
		else stop_with_failure($sformatf("[ERROR] key event is %h, was %h while stalled",
			$sampled({event_extended, event_release, event_code}),
			$past({event_extended, event_release, event_code})));

	initial begin
		#(WATCHDOG_NS);
		stop_with_failure("Timeout, the test sequence did not finish in the allowed time");
	end

	// Applies the set-2 prefix rule to each good byte the keyboard sends
	function automatic void note_byte(input logic [7:0] b);
		if (b == `PS2_PREFIX_EXT) begin
			pend_ext = 1'b1;
		end else if (b == `PS2_PREFIX_BREAK) begin
			pend_rel = 1'b1;
		end else begin
			exp_mem[exp_wr] = {pend_ext, pend_rel, b};
			exp_wr = exp_wr + 1;
			pend_ext = 1'b0;
			pend_rel = 1'b0;
		end
	endfunction

	function automatic logic [7:0] random_make_code();
		logic [7:0] c;
		c = 8'($urandom());
		while (c == `PS2_PREFIX_EXT || c == `PS2_PREFIX_BREAK) begin
			c = 8'($urandom());
		end
		return c;
	endfunction

	task automatic send_code(input logic [7:0] b);
		note_byte(b);
		kbd.send_byte(b);
	endtask

	// Returns once every expected event is out or the DUT had DRAIN_CLKS cycles for them
	task automatic wait_drained();
		int waited;
		waited = 0;
		while (exp_rd != exp_wr && waited < DRAIN_CLKS) begin
			@(posedge clk);
			waited++;
		end
		@(posedge clk);
		#2;
	endtask

	task automatic run_back_pressure();
		event_ready = 1'b0;
		for (int n = 0; n < 11; n++) begin
			if (n < 9) begin
				send_code(random_make_code()); // Eight in the FIFO and one in the event register
			end else begin
				ovr_allowed = 1'b1;
				kbd.send_byte(random_make_code()); // No room left, this byte is dropped
			end
		end
		ovr_allowed = 1'b0;
		assert (ovr_count == 2)
			else stop_with_failure($sformatf("[ERROR] overrun count is %h, expected %h",
				ovr_count, 2));
		event_ready = 1'b1;
		wait_drained();
	endtask

	initial begin
		void'($urandom(SEED));
		clk         = 1'b0;
		rst         = 1'b1;
		event_ready = 1'b1;
		err_allowed = 1'b0;
		ovr_allowed = 1'b0;
		repeat (16) @(posedge clk);
		#2;
		rst = 1'b0;
		assert ({event_valid, frame_error, overrun} == 3'b000)
			else stop_with_failure($sformatf(
				"[ERROR] {event_valid, frame_error, overrun} is %h, expected %h",
				{event_valid, frame_error, overrun}, 3'b000));

		for (int n = 0; n < 20; n++) send_code(random_make_code());
		wait_drained();

		send_code(`PS2_PREFIX_BREAK); // Plain break
		send_code(random_make_code());
		send_code(`PS2_PREFIX_EXT);   // Extended make
		send_code(random_make_code());
		send_code(`PS2_PREFIX_EXT);   // Extended break
		send_code(`PS2_PREFIX_BREAK);
		send_code(random_make_code());
		wait_drained();

		err_allowed = 1'b1;
		kbd.send_bad_parity(8'h1C);
		err_allowed = 1'b0;
		assert (err_count == 1)
			else stop_with_failure($sformatf("[ERROR] frame_error count is %h, expected %h",
				err_count, 1));
		send_code(8'h32);
		wait_drained();

		kbd.send_partial(8'h4B, 5); // Receiver drops back from SHIFT to IDLE on its own
		send_code(8'h2B);
		wait_drained();

		run_back_pressure();

		if (exp_rd == exp_wr) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			stop_with_failure("Expected key events were never delivered");
		end
	end

endmodule

// File: ps2_keyboard_rx.f
+incdir+include
source/ps2_line_pkg.sv
source/key_event_pkg.sv
source/ps2_line_filter.sv
source/ps2_frame_receiver.sv
source/scan_code_fifo.sv
source/scan_code_decoder.sv
source/ps2_keyboard_rx.sv
verif/ps2_keyboard_model.sv
verif/tb_ps2_keyboard_rx.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the PS/2 receiver testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f ps2_keyboard_rx.f \
	--top-module tb_ps2_keyboard_rx --Mdir obj_dir -o tb_ps2_keyboard_rx \
	> build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_ps2_keyboard_rx > sim.log 2>&1
cat sim.log

grep -qx "=== PASS ===" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
